//--- logic/mipsExecPkg.sv
package mipsExecPkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int NumRegs      = 32;
    localparam int FieldWidth   = 6;
    localparam int ImmWidth     = 16;

    // Primary opcode field, instr[31:26]
    typedef enum logic [FieldWidth-1:0] {
        OpRtype = 6'b000000,
        OpBeq   = 6'b000100,
        OpAddi  = 6'b001000,
        OpAddiu = 6'b001001,
        OpSlti  = 6'b001010,
        OpAndi  = 6'b001100,
        OpOri   = 6'b001101,
        OpXori  = 6'b001110
    } opcodeE;

    // R-type funct field, instr[5:0]
    typedef enum logic [FieldWidth-1:0] {
        FnSll  = 6'b000000,
        FnAdd  = 6'b100000,
        FnAddu = 6'b100001,
        FnSub  = 6'b100010,
        FnSubu = 6'b100011,
        FnAnd  = 6'b100100,
        FnOr   = 6'b100101,
        FnXor  = 6'b100110,
        FnNor  = 6'b100111,
        FnSlt  = 6'b101010
    } functE;

    // ALU class from the main decoder
    typedef enum logic [1:0] {
        ClsAdd   = 2'b00,
        ClsSub   = 2'b01,
        ClsFunct = 2'b10,
        ClsImm   = 2'b11
    } aluClassE;

    typedef enum logic [3:0] {
        AluAnd = 4'b0000,
        AluOr  = 4'b0001,
        AluAdd = 4'b0010,
        AluSll = 4'b0011,
        AluSub = 4'b0110,
        AluSlt = 4'b0111,
        AluNor = 4'b1100,
        AluXor = 4'b1101,
        AluBad = 4'b1111  // Unknown funct or opcode
    } aluOpE;

endpackage

//--- logic/ctrlIf.sv
`timescale 1ns/10ps

interface ctrlIf;

    mipsExecPkg::aluClassE aluClass;
    logic                  aluSrcImm;   // Operand B from immediate
    logic                  immZeroExt;  // Zero extend, else sign extend
    logic                  regDstRd;    // Destination rd, else rt
    logic                  regWrite;

    modport decoder (output aluClass, output aluSrcImm, output immZeroExt,
                     output regDstRd, output regWrite);

    modport aluCtl (input aluClass);

    modport datapath (input aluSrcImm, input immZeroExt, input regDstRd, input regWrite);

endinterface

//--- logic/mainDecoder.sv
`timescale 1ns/10ps

module mainDecoder
(
    input  mipsExecPkg::opcodeE opcode,
    ctrlIf.decoder              ctrl,
    output logic                badOpcode
);

    always_comb
    begin
        ctrl.aluClass   = mipsExecPkg::ClsAdd;
        ctrl.aluSrcImm  = 1'b0;
        ctrl.immZeroExt = 1'b0;
        ctrl.regDstRd   = 1'b0;
        ctrl.regWrite   = 1'b0;
        badOpcode       = 1'b0;

        case (opcode)
            mipsExecPkg::OpRtype:
            begin
                ctrl.aluClass = mipsExecPkg::ClsFunct;
                ctrl.regDstRd = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsExecPkg::OpAddi, mipsExecPkg::OpAddiu:
            begin
                ctrl.aluClass  = mipsExecPkg::ClsAdd;  // Plain add, no overflow trap
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            mipsExecPkg::OpSlti:
            begin
                ctrl.aluClass  = mipsExecPkg::ClsImm;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            mipsExecPkg::OpAndi, mipsExecPkg::OpOri, mipsExecPkg::OpXori:
            begin
                ctrl.aluClass   = mipsExecPkg::ClsImm;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.immZeroExt = 1'b1;  // Logical immediates
                ctrl.regWrite   = 1'b1;
            end
            mipsExecPkg::OpBeq:
            begin
                ctrl.aluClass = mipsExecPkg::ClsSub;  // Compare only
            end
            default:
            begin
                badOpcode = 1'b1;
            end
        endcase
    end

endmodule

//--- logic/aluControl.sv
`timescale 1ns/10ps

module aluControl
(
    ctrlIf.aluCtl               ctrl,
    input  mipsExecPkg::functE  funct,
    input  mipsExecPkg::opcodeE opcode,
    output mipsExecPkg::aluOpE  aluOp
);

    always_comb
    begin
        case (ctrl.aluClass)
            mipsExecPkg::ClsAdd:
            begin
                aluOp = mipsExecPkg::AluAdd;
            end
            mipsExecPkg::ClsSub:
            begin
                aluOp = mipsExecPkg::AluSub;
            end
            mipsExecPkg::ClsFunct:
            begin
                case (funct)
                    mipsExecPkg::FnAdd:  aluOp = mipsExecPkg::AluAdd;
                    mipsExecPkg::FnAddu: aluOp = mipsExecPkg::AluAdd;
                    mipsExecPkg::FnSub:  aluOp = mipsExecPkg::AluSub;
                    mipsExecPkg::FnSubu: aluOp = mipsExecPkg::AluSub;
                    mipsExecPkg::FnAnd:  aluOp = mipsExecPkg::AluAnd;
                    mipsExecPkg::FnOr:   aluOp = mipsExecPkg::AluOr;
                    mipsExecPkg::FnNor:  aluOp = mipsExecPkg::AluNor;
                    mipsExecPkg::FnXor:  aluOp = mipsExecPkg::AluXor;
                    mipsExecPkg::FnSlt:  aluOp = mipsExecPkg::AluSlt;
                    mipsExecPkg::FnSll:  aluOp = mipsExecPkg::AluSll;
                    default:             aluOp = mipsExecPkg::AluBad;  // Unsupported funct
                endcase
            end
            mipsExecPkg::ClsImm:
            begin
                // Immediate ops that need more than an add
                case (opcode)
                    mipsExecPkg::OpSlti: aluOp = mipsExecPkg::AluSlt;
                    mipsExecPkg::OpAndi: aluOp = mipsExecPkg::AluAnd;
                    mipsExecPkg::OpOri:  aluOp = mipsExecPkg::AluOr;
                    mipsExecPkg::OpXori: aluOp = mipsExecPkg::AluXor;
                    default:             aluOp = mipsExecPkg::AluBad;
                endcase
            end
            default:
            begin
                aluOp = mipsExecPkg::AluBad;
            end
        endcase
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/10ps

module regFile
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic [mipsExecPkg::RegAddrWidth-1:0] rsAddr,
    input  logic [mipsExecPkg::RegAddrWidth-1:0] rtAddr,
    output logic [mipsExecPkg::DataWidth-1:0]    rsData,
    output logic [mipsExecPkg::DataWidth-1:0]    rtData,
    input  logic                                wrEn,
    input  logic [mipsExecPkg::RegAddrWidth-1:0] wrAddr,
    input  logic [mipsExecPkg::DataWidth-1:0]    wrData
);

    logic [mipsExecPkg::DataWidth-1:0] regs [mipsExecPkg::NumRegs];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < mipsExecPkg::NumRegs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn && wrAddr != '0)  // r0 stays zero
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // Pending write is forwarded so the next instruction sees it
    assign rsData = (rsAddr == '0) ? '0 :
                    (wrEn && wrAddr == rsAddr) ? wrData : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (wrEn && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

//--- logic/aluStage.sv
`timescale 1ns/10ps

module aluStage
(
    input  logic                                 clk,
    input  logic                                 rst,
    ctrlIf.datapath                              ctrl,
    input  logic                                 valid,
    input  logic                                 badOpcode,
    input  mipsExecPkg::aluOpE                   aluOp,
    input  logic [mipsExecPkg::DataWidth-1:0]    rsData,
    input  logic [mipsExecPkg::DataWidth-1:0]    rtData,
    input  logic [mipsExecPkg::ImmWidth-1:0]     imm,
    input  logic [mipsExecPkg::RegAddrWidth-1:0] shamt,
    input  logic [mipsExecPkg::RegAddrWidth-1:0] rtAddr,
    input  logic [mipsExecPkg::RegAddrWidth-1:0] rdAddr,
    output logic [mipsExecPkg::DataWidth-1:0]    result,
    output logic [mipsExecPkg::RegAddrWidth-1:0] resultReg,
    output logic                                 zero,
    output logic                                 resultValid,
    output logic                                 branchDone,
    output logic                                 illegal
);

    localparam int ExtWidth = mipsExecPkg::DataWidth - mipsExecPkg::ImmWidth;

    logic [mipsExecPkg::DataWidth-1:0]    immExt;
    logic [mipsExecPkg::DataWidth-1:0]    opB;
    logic [mipsExecPkg::DataWidth-1:0]    aluResult;
    logic [mipsExecPkg::RegAddrWidth-1:0] destReg;
    logic                                 isBad;
    logic                                 doWrite;

    assign immExt  = ctrl.immZeroExt ? {{ExtWidth{1'b0}}, imm} : {{ExtWidth{imm[15]}}, imm};
    assign opB     = ctrl.aluSrcImm ? immExt : rtData;
    assign destReg = ctrl.regDstRd ? rdAddr : rtAddr;
    assign isBad   = badOpcode || (aluOp == mipsExecPkg::AluBad);
    assign doWrite = ctrl.regWrite && (destReg != '0);  // A write to r0 retires as non-writing

    always_comb
    begin
        case (aluOp)
            mipsExecPkg::AluAnd: aluResult = rsData & opB;
            mipsExecPkg::AluOr:  aluResult = rsData | opB;
            mipsExecPkg::AluNor: aluResult = ~(rsData | opB);
            mipsExecPkg::AluXor: aluResult = rsData ^ opB;
            mipsExecPkg::AluAdd: aluResult = rsData + opB;
            mipsExecPkg::AluSub: aluResult = rsData - opB;
            mipsExecPkg::AluSlt: aluResult = {{(mipsExecPkg::DataWidth-1){1'b0}},
                                              $signed(rsData) < $signed(opB)};
            mipsExecPkg::AluSll: aluResult = rtData << shamt;  // Shifts rt, not rs
            default:             aluResult = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            resultValid <= 1'b0;
            branchDone  <= 1'b0;
            illegal     <= 1'b0;
        end
        else
        begin
            illegal     <= valid && isBad;
            resultValid <= valid && !isBad && doWrite;
            branchDone  <= valid && !isBad && !doWrite;
        end
    end

    // Payload only loads on accepted instructions
    always_ff @(posedge clk)
    begin
        if (valid)
        begin
            result    <= aluResult;
            resultReg <= destReg;
            zero      <= (aluResult == '0);
        end
    end

endmodule

//--- logic/execCore.sv
`timescale 1ns/10ps

module execCore
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 instrValid,
    input  logic [mipsExecPkg::DataWidth-1:0]    instr,
    output logic [mipsExecPkg::DataWidth-1:0]    result,
    output logic [mipsExecPkg::RegAddrWidth-1:0] resultReg,
    output logic                                 zero,
    output logic                                 resultValid,
    output logic                                 branchDone,
    output logic                                 illegal
);

    mipsExecPkg::opcodeE                  opcode;
    mipsExecPkg::functE                   funct;
    mipsExecPkg::aluOpE                   aluOp;
    logic [mipsExecPkg::RegAddrWidth-1:0] rsAddr;
    logic [mipsExecPkg::RegAddrWidth-1:0] rtAddr;
    logic [mipsExecPkg::RegAddrWidth-1:0] rdAddr;
    logic [mipsExecPkg::RegAddrWidth-1:0] shamt;
    logic [mipsExecPkg::ImmWidth-1:0]     imm;
    logic [mipsExecPkg::DataWidth-1:0]    rsData;
    logic [mipsExecPkg::DataWidth-1:0]    rtData;
    logic                                 badOpcode;

    // Instruction fields
    assign opcode = mipsExecPkg::opcodeE'(instr[31:26]);
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rdAddr = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = mipsExecPkg::functE'(instr[5:0]);
    assign imm    = instr[15:0];

    ctrlIf ctrl ();

    mainDecoder mainDecoder_inst (
        .opcode    (opcode),
        .ctrl      (ctrl.decoder),
        .badOpcode (badOpcode)
    );

    aluControl aluControl_inst (
        .ctrl   (ctrl.aluCtl),
        .funct  (funct),
        .opcode (opcode),
        .aluOp  (aluOp)
    );

    // Write port fed back from the registered result
    regFile regFile_inst (
        .clk    (clk),
        .rst    (rst),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .wrEn   (resultValid),
        .wrAddr (resultReg),
        .wrData (result)
    );

    aluStage aluStage_inst (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl.datapath),
        .valid       (instrValid),
        .badOpcode   (badOpcode),
        .aluOp       (aluOp),
        .rsData      (rsData),
        .rtData      (rtData),
        .imm         (imm),
        .shamt       (shamt),
        .rtAddr      (rtAddr),
        .rdAddr      (rdAddr),
        .result      (result),
        .resultReg   (resultReg),
        .zero        (zero),
        .resultValid (resultValid),
        .branchDone  (branchDone),
        .illegal     (illegal)
    );

endmodule

//--- sim/execCore_sva.sv
`timescale 1ns/10ps

module execCoreSva
(
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 instrValid,
    input logic                                 resultValid,
    input logic                                 branchDone,
    input logic                                 illegal,
    input logic [mipsExecPkg::RegAddrWidth-1:0] resultReg
);

    logic anyOutcome;

    assign anyOutcome = resultValid || branchDone || illegal;

    assert property (@(posedge clk) disable iff (rst)
                     $onehot0({resultValid, branchDone, illegal}))
        else $error("More than one outcome strobe is high");

    // One cycle latency, in both directions
    assert property (@(posedge clk) disable iff (rst) instrValid |=> anyOutcome)
        else $error("Accepted instruction produced no outcome");

    assert property (@(posedge clk) disable iff (rst) anyOutcome |-> $past(instrValid))
        else $error("Outcome strobe without an instruction one cycle earlier");

    assert property (@(posedge clk) disable iff (rst) resultValid |-> resultReg != '0)
        else $error("Result reported for register 0");

endmodule

bind execCore execCoreSva execCoreSva_inst (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .resultValid (resultValid),
    .branchDone  (branchDone),
    .illegal     (illegal),
    .resultReg   (resultReg)
);

//--- sim/execCoreTb.sv
`timescale 1ns/10ps

module execCoreTb;

    typedef enum {ExpResult, ExpBranch, ExpIllegal} outcomeE;

    logic        clk;
    logic        rst;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] result;
    logic [4:0]  resultReg;
    logic        zero;
    logic        resultValid;
    logic        branchDone;
    logic        illegal;
    logic [31:0] model [32];  // Reference register file, r0 stays zero
    int          seed;

    execCore execCore_inst (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .result      (result),
        .resultReg   (resultReg),
        .zero        (zero),
        .resultValid (resultValid),
        .branchDone  (branchDone),
        .illegal     (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            failRun($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected));
        end
    endtask

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {mipsExecPkg::OpRtype, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Predicts the outcome from the instruction rules and updates the model
    task automatic modelStep(input logic [31:0] ins, output outcomeE kind,
                             output logic [31:0] val, output logic [4:0] dst);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sExt;
        logic [31:0] zExt;
        logic        legal;
        logic        writes;
        a      = model[ins[25:21]];
        b      = model[ins[20:16]];
        sExt   = {{16{ins[15]}}, ins[15:0]};
        zExt   = {16'h0000, ins[15:0]};
        dst    = ins[20:16];
        val    = '0;
        legal  = 1'b1;
        writes = 1'b1;
        case (ins[31:26])
            mipsExecPkg::OpRtype:
            begin
                dst = ins[15:11];
                case (ins[5:0])
                    mipsExecPkg::FnAdd, mipsExecPkg::FnAddu: val = a + b;
                    mipsExecPkg::FnSub, mipsExecPkg::FnSubu: val = a - b;
                    mipsExecPkg::FnAnd: val = a & b;
                    mipsExecPkg::FnOr:  val = a | b;
                    mipsExecPkg::FnNor: val = ~(a | b);
                    mipsExecPkg::FnXor: val = a ^ b;
                    mipsExecPkg::FnSlt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    mipsExecPkg::FnSll: val = b << ins[10:6];
                    default:            legal = 1'b0;
                endcase
            end
            mipsExecPkg::OpAddi, mipsExecPkg::OpAddiu: val = a + sExt;
            mipsExecPkg::OpSlti: val = ($signed(a) < $signed(sExt)) ? 32'd1 : 32'd0;
            mipsExecPkg::OpAndi: val = a & zExt;
            mipsExecPkg::OpOri:  val = a | zExt;
            mipsExecPkg::OpXori: val = a ^ zExt;
            mipsExecPkg::OpBeq:
            begin
                val    = a - b;  // Compare only
                writes = 1'b0;
            end
            default: legal = 1'b0;
        endcase
        if (!legal)
        begin
            kind = ExpIllegal;
        end
        else if (writes && dst != 5'd0)
        begin
            kind       = ExpResult;
            model[dst] = val;
        end
        else
        begin
            kind = ExpBranch;  // Writes to r0 retire without a write
        end
    endtask

    task automatic issue(input logic [31:0] ins);
        @(posedge clk);
        instr      <= ins;
        instrValid <= 1'b1;
    endtask

    task automatic idle();
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    task automatic collect(input outcomeE kind, input logic [31:0] val, input logic [4:0] dst);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(resultValid || branchDone || illegal) && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        if (!(resultValid || branchDone || illegal))
        begin
            failRun("No outcome strobe appeared within 20 cycles of the instruction");
        end
        else if (waited != 0)
        begin
            failRun($sformatf("Outcome strobe came %0d cycles later than one cycle", waited));
        end
        else
        begin
            checkValue("resultValid", resultValid, kind == ExpResult);
            checkValue("branchDone", branchDone, kind == ExpBranch);
            checkValue("illegal", illegal, kind == ExpIllegal);
            if (kind == ExpResult)
            begin
                checkValue("result", result, val);
                checkValue("resultReg", resultReg, dst);
            end
            if (kind != ExpIllegal)
            begin
                checkValue("zero", zero, val == 32'd0);
            end
        end
    endtask

    task automatic execute(input logic [31:0] ins);
        outcomeE     kind;
        logic [31:0] val;
        logic [4:0]  dst;
        modelStep(ins, kind, val, dst);
        issue(ins);
        idle();
        collect(kind, val, dst);
    endtask

    // Builds a full 32-bit value with ORI, SLL and ORI
    task automatic loadReg(input logic [4:0] r, input logic [31:0] value);
        execute(iType(mipsExecPkg::OpOri, 5'd0, r, value[31:16]));
        execute(rType(r, r, r, 5'd16, mipsExecPkg::FnSll));
        execute(iType(mipsExecPkg::OpOri, r, r, value[15:0]));
    endtask

    task automatic resetTest();
        @(negedge clk);
        checkValue("resultValid", resultValid, 1'b0);
        checkValue("branchDone", branchDone, 1'b0);
        checkValue("illegal", illegal, 1'b0);
        execute(rType(5'd0, 5'd0, 5'd5, 5'd0, mipsExecPkg::FnAdd));
        checkValue("result", result, 32'h0);
        checkValue("zero", zero, 1'b1);
    endtask

    task automatic immTest();
        logic [5:0] ops [6];
        ops = '{mipsExecPkg::OpAddi, mipsExecPkg::OpAddiu, mipsExecPkg::OpSlti,
                mipsExecPkg::OpAndi, mipsExecPkg::OpOri, mipsExecPkg::OpXori};
        for (int r = 1; r < 8; r++)
        begin
            loadReg(r, $urandom());
        end
        foreach (ops[i])
        begin
            for (int n = 0; n < 4; n++)
            begin
                execute(iType(ops[i], $urandom_range(1, 7), $urandom_range(8, 15), $urandom()));
            end
        end
    endtask

    task automatic rTypeTest();
        logic [5:0] fns [10];
        fns = '{mipsExecPkg::FnAdd, mipsExecPkg::FnAddu, mipsExecPkg::FnSub,
                mipsExecPkg::FnSubu, mipsExecPkg::FnAnd, mipsExecPkg::FnOr,
                mipsExecPkg::FnNor, mipsExecPkg::FnXor, mipsExecPkg::FnSlt,
                mipsExecPkg::FnSll};
        foreach (fns[i])
        begin
            for (int n = 0; n < 3; n++)
            begin
                execute(rType($urandom_range(1, 15), $urandom_range(1, 15),
                              $urandom_range(16, 31), $urandom_range(0, 31), fns[i]));
            end
        end
    endtask

    task automatic bypassTest();
        logic [31:0] ins [3];
        outcomeE     kind [3];
        logic [31:0] val [3];
        logic [4:0]  dst [3];
        loadReg(5'd1, $urandom());
        ins[0] = rType(5'd1, 5'd1, 5'd2, 5'd0, mipsExecPkg::FnAddu);  // r2 = r1 + r1
        ins[1] = rType(5'd2, 5'd1, 5'd3, 5'd0, mipsExecPkg::FnSub);   // r3 = r2 - r1
        ins[2] = rType(5'd3, 5'd2, 5'd4, 5'd0, mipsExecPkg::FnXor);   // r4 = r3 ^ r2
        foreach (ins[i])
        begin
            modelStep(ins[i], kind[i], val[i], dst[i]);
        end
        issue(ins[0]);
        issue(ins[1]);
        collect(kind[0], val[0], dst[0]);
        issue(ins[2]);
        collect(kind[1], val[1], dst[1]);
        idle();
        collect(kind[2], val[2], dst[2]);
        // Write to r0, then read it on the next cycle
        ins[0] = iType(mipsExecPkg::OpAddi, 5'd1, 5'd0, $urandom());
        ins[1] = rType(5'd0, 5'd1, 5'd6, 5'd0, mipsExecPkg::FnOr);
        modelStep(ins[0], kind[0], val[0], dst[0]);
        modelStep(ins[1], kind[1], val[1], dst[1]);
        issue(ins[0]);
        issue(ins[1]);
        collect(kind[0], val[0], dst[0]);
        idle();
        collect(kind[1], val[1], dst[1]);
        checkValue("result", result, model[1]);
    endtask

    task automatic beqTest();
        logic [31:0] value;
        value = $urandom();
        loadReg(5'd9, value);
        loadReg(5'd10, value);
        loadReg(5'd11, value ^ 32'h0000_0100);
        execute(iType(mipsExecPkg::OpBeq, 5'd9, 5'd10, 16'h0004));
        checkValue("zero", zero, 1'b1);
        execute(iType(mipsExecPkg::OpBeq, 5'd9, 5'd11, 16'h0004));
        checkValue("zero", zero, 1'b0);
        execute(rType(5'd10, 5'd0, 5'd12, 5'd0, mipsExecPkg::FnAddu));  // Compare rt unchanged
        checkValue("result", result, value);
        execute(rType(5'd11, 5'd0, 5'd12, 5'd0, mipsExecPkg::FnAddu));
        checkValue("result", result, value ^ 32'h0000_0100);
    endtask

    task automatic illegalTest();
        execute(iType(6'b100011, 5'd1, 5'd20, $urandom()));              // Load word
        execute(rType(5'd1, 5'd2, 5'd21, 5'd3, 6'b000010));               // Shift right
        execute(iType(6'b001111, 5'd1, 5'd22, $urandom()));              // LUI
        for (int r = 20; r < 23; r++)
        begin
            execute(rType(r, 5'd0, 5'd23, 5'd0, mipsExecPkg::FnOr));  // Targets unchanged
        end
    endtask

    initial
    begin
        seed = 32'hf45d;
        void'($urandom(seed));
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        foreach (model[i])
        begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        resetTest();
        immTest();
        rTypeTest();
        bypassTest();
        beqTest();
        illegalTest();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- build.f
logic/mipsExecPkg.sv
logic/ctrlIf.sv
logic/mainDecoder.sv
logic/aluControl.sv
logic/regFile.sv
logic/aluStage.sv
logic/execCore.sv
sim/execCore_sva.sv
sim/execCoreTb.sv

//--- Bender.yml
package:
  name: mips_exec_core

sources:
  - logic/mipsExecPkg.sv
  - logic/ctrlIf.sv
  - logic/mainDecoder.sv
  - logic/aluControl.sv
  - logic/regFile.sv
  - logic/aluStage.sv
  - logic/execCore.sv
  - target: simulation
    files:
      - sim/execCore_sva.sv
      - sim/execCoreTb.sv
